//--- sim.f
+incdir+verification
logic/fft_pkg.sv
logic/decimal_unpack.sv
logic/fft_stage1.sv
logic/twiddle_mult.sv
logic/fft_stage2.sv
logic/fft_stage3.sv
logic/decimal_pack.sv
logic/decimal_fft.sv
verification/tb_decimal_fft.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decimal_fft
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- verification/fft_model.svh
// ------------------------------------------------------------
// stimulus and result records
// ------------------------------------------------------------

// one input set as it sits on the rin_* ports
typedef struct packed {
    whole_t [fft_points-1:0] whole;
    frac_t  [fft_points-1:0] frac;
    logic   [fft_points-1:0] flag;
} sample_set_t;

// eight bins in the output field format
typedef struct packed {
    whole_t [fft_points-1:0] re_whole;
    frac_t  [fft_points-1:0] re_frac;
    logic   [fft_points-1:0] re_flag;
    whole_t [fft_points-1:0] im_whole;
    frac_t  [fft_points-1:0] im_frac;
    logic   [fft_points-1:0] im_flag;
} bins_t;

// right-shifting Galois LFSR, x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] lfsr_taps = 32'h8020_0003;

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ lfsr_taps;
    end
    return state >> 1;
endfunction

// ------------------------------------------------------------
// decimal conversions
// ------------------------------------------------------------

// the fraction follows the sign of the whole part, the flag covers -1 < v < 0
function automatic longint to_hundredths(input whole_t whole, input frac_t frac,
                                         input logic flag);
    longint mag;
    mag = longint'(frac);
    if (flag) begin
        return -mag;
    end
    if (whole < 0) begin
        mag = -mag;
    end
    return longint'(whole) * frac_scale + mag;
endfunction

// product of two hundredths values, truncated toward zero
function automatic longint trunc_mul(input longint a, input longint b);
    return (a * b) / frac_scale;
endfunction

function automatic whole_t whole_of(input longint v);
    if (v < 0) begin
        return whole_t'(-((-v) / frac_scale));
    end
    return whole_t'(v / frac_scale);
endfunction

function automatic frac_t frac_of(input longint v);
    return frac_t'(((v < 0) ? -v : v) % frac_scale);
endfunction

function automatic logic flag_of(input longint v);
    return (v < 0) && (v > -frac_scale);
endfunction

function automatic int bit_reverse(input int n);
    int r;
    r = 0;
    for (int b = 0; b < $clog2(fft_points); b++) begin
        r = (r << 1) | ((n >> b) & 1);
    end
    return r;
endfunction

// ------------------------------------------------------------
// reference FFT, iterative radix-2 DIT over a twiddle table
// ------------------------------------------------------------
function automatic bins_t fft_reference(input sample_set_t s);
    longint a_re [fft_points];
    longint a_im [fft_points];
    longint w_re [fft_points/2];
    longint w_im [fft_points/2];
    longint t_re;
    longint t_im;
    int     lo;
    int     hi;
    bins_t  b;
    w_re = '{longint'(frac_scale), longint'(twiddle_mag), 0, -longint'(twiddle_mag)};
    w_im = '{0, -longint'(twiddle_mag), -longint'(frac_scale), -longint'(twiddle_mag)};
    for (int n = 0; n < fft_points; n++) begin
        a_re[bit_reverse(n)] = to_hundredths(s.whole[n], s.frac[n], s.flag[n]);
        a_im[n] = 0;
    end
    for (int span = 1; span < fft_points; span *= 2) begin
        for (int base = 0; base < fft_points; base += 2 * span) begin
            for (int j = 0; j < span; j++) begin
                lo = base + j;
                hi = lo + span;
                // W^(j * N / 2span), unity and -j stay exact under truncation
                t_re = trunc_mul(a_re[hi], w_re[j * (fft_points / (2 * span))])
                     - trunc_mul(a_im[hi], w_im[j * (fft_points / (2 * span))]);
                t_im = trunc_mul(a_re[hi], w_im[j * (fft_points / (2 * span))])
                     + trunc_mul(a_im[hi], w_re[j * (fft_points / (2 * span))]);
                a_re[hi] = a_re[lo] - t_re;
                a_im[hi] = a_im[lo] - t_im;
                a_re[lo] = a_re[lo] + t_re;
                a_im[lo] = a_im[lo] + t_im;
            end
        end
    end
    for (int k = 0; k < fft_points; k++) begin
        b.re_whole[k] = whole_of(a_re[k]);
        b.re_frac[k]  = frac_of(a_re[k]);
        b.re_flag[k]  = flag_of(a_re[k]);
        b.im_whole[k] = whole_of(a_im[k]);
        b.im_frac[k]  = frac_of(a_im[k]);
        b.im_flag[k]  = flag_of(a_im[k]);
    end
    return b;
endfunction

//--- verification/tb_decimal_fft.sv
`timescale 1ns/1ns
`default_nettype none

module tb_decimal_fft;

    import fft_pkg::*;

    `include "fft_model.svh"

    localparam int          pipe_edges     = 4;
    localparam int          random_sets    = 200;
    localparam int          result_timeout = 20;
    localparam int          whole_limit    = 99;
    localparam logic [31:0] lfsr_seed      = 32'd71067;

    logic        clk;
    logic        rst;
    sample_set_t stim;
    whole_t      rin_whole  [fft_points];
    frac_t       rin_frac   [fft_points];
    logic        rin_flag   [fft_points];
    whole_t      rout_whole [fft_points];
    frac_t       rout_frac  [fft_points];
    logic        rout_flag  [fft_points];
    whole_t      iout_whole [fft_points];
    frac_t       iout_frac  [fft_points];
    logic        iout_flag  [fft_points];

    logic [31:0] lfsr_state;
    bins_t       pending_q [$];
    int          checks;
    int          value_errors;
    int          latency_errors;
    int          timeouts;

    decimal_fft i_decimal_fft (
        .clk        (clk),
        .rst        (rst),
        .rin_whole  (rin_whole),
        .rin_frac   (rin_frac),
        .rin_flag   (rin_flag),
        .rout_whole (rout_whole),
        .rout_frac  (rout_frac),
        .rout_flag  (rout_flag),
        .iout_whole (iout_whole),
        .iout_frac  (iout_frac),
        .iout_flag  (iout_flag)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // the input set is updated as a whole on the rising edge
    always_comb begin
        for (int n = 0; n < fft_points; n++) begin
            rin_whole[n] = stim.whole[n];
            rin_frac[n]  = stim.frac[n];
            rin_flag[n]  = stim.flag[n];
        end
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic int rand_bits(input int width);
        int r;
        r = 0;
        for (int i = 0; i < width; i++) begin
            r = (r << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic sample_set_t random_set();
        sample_set_t s;
        for (int n = 0; n < fft_points; n++) begin
            if (rand_bits(2) == 0) begin
                // fraction-only values, negative ones through the flag
                s.whole[n] = '0;
                s.flag[n]  = (rand_bits(1) != 0);
            end else begin
                s.whole[n] = whole_t'(rand_bits(8) % (2 * whole_limit + 1) - whole_limit);
                s.flag[n]  = 1'b0;
            end
            s.frac[n] = frac_t'(rand_bits(7) % frac_scale);
        end
        return s;
    endfunction

    task automatic compare_field(input string name, input int lane, input int got,
                                 input int want);
        checks++;
        assert (got == want) else begin
            value_errors++;
            $display("CHECK FAILED at %0t ns: %s[%0d] is %0d, expected %0d",
                     $time, name, lane, got, want);
        end
    endtask

    task automatic expect_bin(input int k, input int rw, input int rf, input int rfl,
                              input int iw, input int ifr, input int ifl);
        compare_field("rout_whole", k, int'(rout_whole[k]), rw);
        compare_field("rout_frac", k, int'(rout_frac[k]), rf);
        compare_field("rout_flag", k, int'(rout_flag[k]), rfl);
        compare_field("iout_whole", k, int'(iout_whole[k]), iw);
        compare_field("iout_frac", k, int'(iout_frac[k]), ifr);
        compare_field("iout_flag", k, int'(iout_flag[k]), ifl);
    endtask

    task automatic compare_bins(input bins_t want);
        for (int k = 0; k < fft_points; k++) begin
            expect_bin(k, int'(whole_t'(want.re_whole[k])), int'(want.re_frac[k]),
                       int'(want.re_flag[k]), int'(whole_t'(want.im_whole[k])),
                       int'(want.im_frac[k]), int'(want.im_flag[k]));
        end
    endtask

    // polls the real part of one bin at falling edges
    task automatic wait_for_bin(input int bin, input int whole, input int frac,
                                input logic flag, output int edges);
        int n;
        n = 0;
        edges = -1;
        while (edges < 0 && n < result_timeout) begin
            @(negedge clk);
            n++;
            if (int'(rout_whole[bin]) == whole && int'(rout_frac[bin]) == frac
                    && rout_flag[bin] == flag) begin
                edges = n - 1;
            end
        end
        if (edges < 0) begin
            timeouts++;
            $display("timeout: real part of bin %0d never reached the expected value", bin);
        end
    endtask

    task automatic check_latency(input int edges);
        assert (edges == pipe_edges) else begin
            latency_errors++;
            $display("result arrived %0d edges after sampling instead of %0d",
                     edges, pipe_edges);
        end
    endtask

    // ------------------------------------------------------------
    // output check, one compare per cycle against the delayed model
    // ------------------------------------------------------------
    initial begin : output_check
        bins_t want;
        want = '0;
        // registers come out of reset at zero
        repeat (pipe_edges) pending_q.push_back(want);
        forever begin
            @(negedge clk);
            want = pending_q.pop_front();
            compare_bins(want);
            // bins 0 and 4 of a real input have no imaginary part
            for (int k = 0; k < fft_points; k += fft_points / 2) begin
                compare_field("iout_whole", k, int'(iout_whole[k]), 0);
                compare_field("iout_frac", k, int'(iout_frac[k]), 0);
                compare_field("iout_flag", k, int'(iout_flag[k]), 0);
            end
            pending_q.push_back(fft_reference(stim));
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin : stimulus
        sample_set_t half_set;
        sample_set_t impulse;
        int          edges;
        rst            = 1'b1;
        stim           = '0;
        lfsr_state     = lfsr_seed;
        checks         = 0;
        value_errors   = 0;
        latency_errors = 0;
        timeouts       = 0;
        half_set       = '0;
        impulse        = '0;
        for (int n = 0; n < fft_points; n++) begin
            half_set.frac[n] = frac_t'(50);
            half_set.flag[n] = 1'b1;
        end
        impulse.frac[1] = frac_t'(99);

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        // all lanes at -0.50, everything lands in bin 0 as -4.00
        stim <= half_set;
        wait_for_bin(0, -4, 0, 1'b0, edges);
        check_latency(edges);
        expect_bin(0, -4, 0, 0, 0, 0, 0);
        for (int k = 1; k < fft_points; k++) begin
            expect_bin(k, 0, 0, 0, 0, 0, 0);
        end

        // 0.99 on input 1, bin 3 comes out at -0.69 - j0.69
        @(posedge clk);
        stim <= impulse;
        wait_for_bin(3, 0, 69, 1'b1, edges);
        check_latency(edges);
        expect_bin(3, 0, 69, 1, 0, 69, 1);
        expect_bin(0, 0, 99, 0, 0, 0, 0);

        // back-to-back random sets
        for (int i = 0; i < random_sets; i++) begin
            @(posedge clk);
            stim <= random_set();
        end
        @(posedge clk);
        stim <= '0;
        repeat (pipe_edges + 2) @(posedge clk);

        $display("checks: %0d, value mismatches: %0d, latency errors: %0d, timeouts: %0d",
                 checks, value_errors, latency_errors, timeouts);
        if (value_errors == 0 && latency_errors == 0 && timeouts == 0 && checks > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/decimal_fft.sv
`timescale 1ns/1ns
`default_nettype none

module decimal_fft (
    input  wire                  clk,
    input  wire                  rst,
    input  wire fft_pkg::whole_t rin_whole [fft_pkg::fft_points],
    input  wire fft_pkg::frac_t  rin_frac  [fft_pkg::fft_points],
    input  wire                  rin_flag  [fft_pkg::fft_points],
    output wire fft_pkg::whole_t rout_whole [fft_pkg::fft_points],
    output wire fft_pkg::frac_t  rout_frac  [fft_pkg::fft_points],
    output wire                  rout_flag  [fft_pkg::fft_points],
    output wire fft_pkg::whole_t iout_whole [fft_pkg::fft_points],
    output wire fft_pkg::frac_t  iout_frac  [fft_pkg::fft_points],
    output wire                  iout_flag  [fft_pkg::fft_points]
);

    // bit-reversed samples, stage 1 and stage 2 registers, stage 3 bins
    wire fft_pkg::fixed_t x    [fft_pkg::fft_points];
    wire fft_pkg::fixed_t f    [fft_pkg::fft_points];
    wire fft_pkg::fixed_t s_re [fft_pkg::fft_points];
    wire fft_pkg::fixed_t s_im [fft_pkg::fft_points];
    wire fft_pkg::fixed_t y_re [fft_pkg::fft_points];
    wire fft_pkg::fixed_t y_im [fft_pkg::fft_points];

    // ------------------------------------------------------------
    // input buffer, lanes reordered on the way in
    // ------------------------------------------------------------
    for (genvar n = 0; n < fft_pkg::fft_points; n++) begin : g_unpack
        decimal_unpack i_unpack (
            .clk   (clk),
            .rst   (rst),
            .whole (rin_whole[n]),
            .frac  (rin_frac[n]),
            .flag  (rin_flag[n]),
            .value (x[fft_pkg::bitrev_idx[n]])
        );
    end

    // ------------------------------------------------------------
    // butterfly stages
    // ------------------------------------------------------------
    fft_stage1 i_stage1 (
        .clk (clk),
        .rst (rst),
        .x   (x),
        .f   (f)
    );

    fft_stage2 i_stage2 (
        .clk  (clk),
        .rst  (rst),
        .f    (f),
        .s_re (s_re),
        .s_im (s_im)
    );

    // combinational, lands in the pack registers on the same edge
    fft_stage3 i_stage3 (
        .s_re (s_re),
        .s_im (s_im),
        .y_re (y_re),
        .y_im (y_im)
    );

    // ------------------------------------------------------------
    // output register, one per bin
    // ------------------------------------------------------------
    for (genvar k = 0; k < fft_pkg::fft_points; k++) begin : g_pack
        decimal_pack i_pack (
            .clk      (clk),
            .rst      (rst),
            .re       (y_re[k]),
            .im       (y_im[k]),
            .re_whole (rout_whole[k]),
            .re_frac  (rout_frac[k]),
            .re_flag  (rout_flag[k]),
            .im_whole (iout_whole[k]),
            .im_frac  (iout_frac[k]),
            .im_flag  (iout_flag[k])
        );
    end

endmodule

`default_nettype wire

//--- logic/decimal_pack.sv
`timescale 1ns/1ns
`default_nettype none

module decimal_pack (
    input  wire             clk,
    input  wire             rst,
    input  wire fft_pkg::fixed_t re,
    input  wire fft_pkg::fixed_t im,
    output fft_pkg::whole_t re_whole,
    output fft_pkg::frac_t  re_frac,
    output logic            re_flag,
    output fft_pkg::whole_t im_whole,
    output fft_pkg::frac_t  im_frac,
    output logic            im_flag
);

    import fft_pkg::*;

    // whole part truncates toward zero
    function automatic whole_t to_whole(input fixed_t v);
        return whole_t'(v / frac_scale);
    endfunction

    // fraction is the magnitude of the remainder
    function automatic frac_t to_frac(input fixed_t v);
        fixed_t rem;
        rem = v % frac_scale;
        if (rem < 0) begin
            rem = -rem;
        end
        return frac_t'(rem);
    endfunction

    // set only when the whole part is zero but the value is negative
    function automatic logic to_flag(input fixed_t v);
        return (v < 0) && (v > -fixed_t'(frac_scale));
    endfunction

    // output register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            re_whole <= '0;
            re_frac  <= '0;
            re_flag  <= 1'b0;
            im_whole <= '0;
            im_frac  <= '0;
            im_flag  <= 1'b0;
        end else begin
            re_whole <= to_whole(re);
            re_frac  <= to_frac(re);
            re_flag  <= to_flag(re);
            im_whole <= to_whole(im);
            im_frac  <= to_frac(im);
            im_flag  <= to_flag(im);
        end
    end

endmodule

`default_nettype wire

//--- logic/fft_stage3.sv
`timescale 1ns/1ns
`default_nettype none

module fft_stage3 (
    input  wire fft_pkg::fixed_t s_re [fft_pkg::fft_points],
    input  wire fft_pkg::fixed_t s_im [fft_pkg::fft_points],
    output fft_pkg::fixed_t      y_re [fft_pkg::fft_points],
    output fft_pkg::fixed_t      y_im [fft_pkg::fft_points]
);

    import fft_pkg::*;

    // ------------------------------------------------------------
    // final butterflies across a span of half the points
    // ------------------------------------------------------------

    // twiddles were already applied in stage 2, so this is add/sub only
    always_comb begin
        for (int k = 0; k < fft_points / 2; k++) begin
            y_re[k] = s_re[k] + s_re[k + fft_points / 2];
            y_im[k] = s_im[k] + s_im[k + fft_points / 2];

            y_re[k + fft_points / 2] = s_re[k] - s_re[k + fft_points / 2];
            y_im[k + fft_points / 2] = s_im[k] - s_im[k + fft_points / 2];
        end
    end

endmodule

`default_nettype wire

//--- logic/fft_stage2.sv
`timescale 1ns/1ns
`default_nettype none

module fft_stage2 (
    input  wire             clk,
    input  wire             rst,
    input  wire fft_pkg::fixed_t f [fft_pkg::fft_points],
    output fft_pkg::fixed_t s_re [fft_pkg::fft_points],
    output fft_pkg::fixed_t s_im [fft_pkg::fft_points]
);

    import fft_pkg::*;

    fixed_t pre_re [fft_points];
    fixed_t pre_im [fft_points];
    fixed_t tw_re [5:7];
    fixed_t tw_im [5:7];
    fixed_t nxt_re [fft_points];
    fixed_t nxt_im [fft_points];

    // ------------------------------------------------------------
    // size-4 combine, one group per half
    // ------------------------------------------------------------
    always_comb begin
        for (int g = 0; g < fft_points; g += fft_points / 2) begin
            pre_re[g]     = f[g] + f[g+2];
            pre_im[g]     = '0;
            pre_re[g + 2] = f[g] - f[g+2];
            pre_im[g + 2] = '0;
            // odd lanes take the -j factor on the lower leg
            pre_re[g + 1] = f[g+1];
            pre_im[g + 1] = -f[g+3];
            pre_re[g + 3] = f[g+1];
            pre_im[g + 3] = f[g+3];
        end
    end

    // upper group picks up W1..W3 before the third stage
    twiddle_mult i_tw5 (
        .sel    (tw_w1),
        .re_in  (pre_re[5]),
        .im_in  (pre_im[5]),
        .re_out (tw_re[5]),
        .im_out (tw_im[5])
    );

    twiddle_mult i_tw6 (
        .sel    (tw_w2),
        .re_in  (pre_re[6]),
        .im_in  (pre_im[6]),
        .re_out (tw_re[6]),
        .im_out (tw_im[6])
    );

    twiddle_mult i_tw7 (
        .sel    (tw_w3),
        .re_in  (pre_re[7]),
        .im_in  (pre_im[7]),
        .re_out (tw_re[7]),
        .im_out (tw_im[7])
    );

    always_comb begin
        for (int i = 0; i < 5; i++) begin
            nxt_re[i] = pre_re[i];
            nxt_im[i] = pre_im[i];
        end
        for (int i = 5; i < fft_points; i++) begin
            nxt_re[i] = tw_re[i];
            nxt_im[i] = tw_im[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < fft_points; i++) begin
                s_re[i] <= '0;
                s_im[i] <= '0;
            end
        end else begin
            for (int i = 0; i < fft_points; i++) begin
                s_re[i] <= nxt_re[i];
                s_im[i] <= nxt_im[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/twiddle_mult.sv
`timescale 1ns/1ns
`default_nettype none

module twiddle_mult (
    input  wire fft_pkg::twiddle_sel_t sel,
    input  wire fft_pkg::fixed_t       re_in,
    input  wire fft_pkg::fixed_t       im_in,
    output fft_pkg::fixed_t            re_out,
    output fft_pkg::fixed_t            im_out
);

    import fft_pkg::*;

    fixed_t w_re;
    fixed_t w_im;

    // decimal product, the /100 truncates toward zero
    function automatic fixed_t dec_mul(input fixed_t a, input fixed_t b);
        logic signed [63:0] prod;
        prod = 64'(a) * 64'(b);
        return fixed_t'(prod / frac_scale);
    endfunction

    // twiddle constants in hundredths
    always_comb begin
        case (sel)
            tw_w1: begin
                w_re = fixed_t'(twiddle_mag);
                w_im = -fixed_t'(twiddle_mag);
            end
            tw_w2: begin
                w_re = '0;
                w_im = -fixed_t'(frac_scale);
            end
            tw_w3: begin
                w_re = -fixed_t'(twiddle_mag);
                w_im = -fixed_t'(twiddle_mag);
            end
            default: begin
                w_re = fixed_t'(frac_scale);
                w_im = '0;
            end
        endcase
    end

    // (a + jb)(c + jd), each of the four products truncated on its own
    always_comb begin
        re_out = dec_mul(re_in, w_re) - dec_mul(im_in, w_im);
        im_out = dec_mul(re_in, w_im) + dec_mul(im_in, w_re);
    end

endmodule

`default_nettype wire

//--- logic/fft_stage1.sv
`timescale 1ns/1ns
`default_nettype none

module fft_stage1 (
    input  wire             clk,
    input  wire             rst,
    input  wire fft_pkg::fixed_t x [fft_pkg::fft_points],
    output fft_pkg::fixed_t f [fft_pkg::fft_points]
);

    import fft_pkg::*;

    fixed_t bfly [fft_points];

    // size-2 butterflies on neighbouring lanes, inputs are already bit-reversed
    always_comb begin
        for (int k = 0; k < fft_points; k += 2) begin
            bfly[k]     = x[k] + x[k+1];
            bfly[k + 1] = x[k] - x[k+1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < fft_points; i++) begin
                f[i] <= '0;
            end
        end else begin
            for (int i = 0; i < fft_points; i++) begin
                f[i] <= bfly[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/decimal_unpack.sv
`timescale 1ns/1ns
`default_nettype none

module decimal_unpack (
    input  wire            clk,
    input  wire            rst,
    input  wire fft_pkg::whole_t whole,
    input  wire fft_pkg::frac_t  frac,
    input  wire            flag,
    output fft_pkg::fixed_t value
);

    import fft_pkg::*;

    fixed_t frac_ext;
    fixed_t conv;

    always_comb begin
        frac_ext = fixed_t'(frac);
        if (flag) begin
            // whole part is zero, sign lives in the flag
            conv = -frac_ext;
        end else if (whole < 0) begin
            conv = fixed_t'(whole) * frac_scale - frac_ext;
        end else begin
            conv = fixed_t'(whole) * frac_scale + frac_ext;
        end
    end

    // input buffer stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            value <= '0;
        end else begin
            value <= conv;
        end
    end

endmodule

`default_nettype wire

//--- logic/fft_pkg.sv
`default_nettype none

package fft_pkg;

    // ------------------------------------------------------------
    // sizes and decimal format
    // ------------------------------------------------------------

    // samples in, bins out
    localparam int fft_points = 8;

    // hundredths per unit, the decimal fraction has two digits
    localparam int frac_scale = 100;

    // 0.707 truncated to two digits
    localparam int twiddle_mag = 70;

    // input n lands on lane bitrev_idx[n] ahead of the first butterflies
    localparam int bitrev_idx [fft_points] = '{0, 4, 2, 6, 1, 5, 3, 7};

    // ------------------------------------------------------------
    // number types
    // ------------------------------------------------------------

    // signed whole part of a decimal field
    typedef logic signed [15:0] whole_t;

    // two-digit fraction, 0 to 99
    typedef logic [15:0] frac_t;

    // one value in hundredths, wide enough for growth over three stages
    typedef logic signed [31:0] fixed_t;

    // fixed twiddle choice
    // w0 is unity, w1 = 0.70 - j0.70, w2 = -j, w3 = -0.70 - j0.70
    typedef enum logic [1:0] {
        tw_w0 = 2'd0,
        tw_w1 = 2'd1,
        tw_w2 = 2'd2,
        tw_w3 = 2'd3
    } twiddle_sel_t;

endpackage

`default_nettype wire
